// ==== hw/mem_map_pkg.sv ====
package mem_map_pkg;

    // Download stream layout, in byte addresses
    localparam logic [24:0] HEADER_LEN = 25'd16;
    localparam logic [24:0] GFX_START  = 25'h04_0010;  // Header plus 256 kB of main ROM

    // Word offsets inside each SDRAM bank
    localparam logic [21:0] RAM_OFFSET = 22'h10_0000;  // Main RAM/VRAM sits above the ROM
    localparam logic [21:0] ROM_OFFSET = 22'h00_0000;
    localparam logic [21:0] GFX_OFFSET = 22'h00_0000;

    // Bank of each region
    localparam logic RAM_BANK = 1'b0;
    localparam logic ROM_BANK = 1'b0;
    localparam logic GFX_BANK = 1'b1;

    // Header byte positions
    localparam logic [24:0] HDR_CFG_BYTE = 25'd0;
    localparam logic [24:0] HDR_ID_BYTE  = 25'd1;

    // Flags inside the config byte
    localparam int CFG_TYPE_BIT   = 0;
    localparam int CFG_FD1089_BIT = 1;
    localparam int CFG_FD1094_BIT = 2;

endpackage

// ==== hw/outrun_mem.sv ====
`timescale 1ns/10ps

module outrun_mem
    import mem_map_pkg::*, sdram_if_pkg::*;
#(
    parameter logic [24:0] HDR_LEN  = HEADER_LEN,
    parameter logic [24:0] GFX_BASE = GFX_START,
    parameter logic [21:0] RAM_OFS  = RAM_OFFSET,
    parameter logic [21:0] ROM_OFS  = ROM_OFFSET,
    parameter logic [21:0] GFX_OFS  = GFX_OFFSET
) (
    input  logic        clk,
    input  logic        rst_n,

    // ROM download
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output logic        dwnld_busy,

    output logic [1:0]  game_id,
    output logic        dec_en,
    output logic        dec_type,

    // Client slots
    input  slot_req_t   ram_req,
    input  slot_req_t   rom_req,
    input  slot_req_t   gfx_req,
    output logic [15:0] ram_data,
    output logic [15:0] rom_data,
    output logic [15:0] gfx_data,
    output logic        ram_ok,
    output logic        rom_ok,
    output logic        gfx_ok,

    input  logic        lvbl,
    input  logic [8:0]  vrender,

    output sdram_req_t  sdram_req,
    input  sdram_rsp_t  sdram_rsp
);

    sdram_req_t prog_req;
    logic       prog_ack;
    slot_req_t  gfx_gated;
    logic       gfx_gate;
    slot_id_t   rd_slot;
    slot_id_t   busy_slot;
    logic       rd_start;
    logic       fd1089_en;
    logic       fd1094_en;

    // Graphics reads only in blanking
    assign gfx_gate = lvbl || vrender == 9'd0 || vrender[8];

    always_comb begin
        gfx_gated    = gfx_req;
        gfx_gated.cs = gfx_req.cs & gfx_gate;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_en <= 1'b0;
        end else begin
            dec_en <= fd1089_en | fd1094_en;
        end
    end

    rom_dwnld #(
        .HDR_LEN     (HDR_LEN),
        .GFX_BASE    (GFX_BASE)
    ) u_dwnld (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .prog_ack    (prog_ack),
        .prog_req    (prog_req),
        .dwnld_busy  (dwnld_busy),
        .game_id     (game_id),
        .fd1089_en   (fd1089_en),
        .fd1094_en   (fd1094_en),
        .dec_type    (dec_type)
    );

    slot_arbiter #(
        .RAM_OFS     (RAM_OFS),
        .ROM_OFS     (ROM_OFS),
        .GFX_OFS     (GFX_OFS)
    ) u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .prog_req    (prog_req),
        .prog_ack    (prog_ack),
        .ram_req     (ram_req),
        .rom_req     (rom_req),
        .gfx_req     (gfx_gated),
        .sdram_req   (sdram_req),
        .sdram_rsp   (sdram_rsp),
        .rd_slot     (rd_slot),
        .rd_start    (rd_start),
        .busy_slot   (busy_slot)
    );

    slot_return u_return (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_start    (rd_start),
        .rd_slot     (rd_slot),
        .busy_slot   (busy_slot),
        .sdram_rsp   (sdram_rsp),
        .ram_req     (ram_req),
        .rom_req     (rom_req),
        .gfx_req     (gfx_gated),
        .ram_data    (ram_data),
        .rom_data    (rom_data),
        .gfx_data    (gfx_data),
        .ram_ok      (ram_ok),
        .rom_ok      (rom_ok),
        .gfx_ok      (gfx_ok)
    );

endmodule

// ==== hw/rom_dwnld.sv ====
`timescale 1ns/10ps

module rom_dwnld
    import mem_map_pkg::*, sdram_if_pkg::*;
#(
    parameter logic [24:0] HDR_LEN  = HEADER_LEN,
    parameter logic [24:0] GFX_BASE = GFX_START
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,

    input  logic        prog_ack,
    output sdram_req_t  prog_req,
    output logic        dwnld_busy,

    output logic [1:0]  game_id,
    output logic        fd1089_en,
    output logic        fd1094_en,
    output logic        dec_type
);

    logic        header;
    logic        in_gfx;
    logic [24:0] rel_addr;
    logic        byte_wr;
    logic [7:0]  low_byte;
    logic        prog_valid;
    logic        prog_bank;
    logic [21:0] prog_addr;
    logic [15:0] prog_data;

    assign header   = ioctl_addr < HDR_LEN;
    assign in_gfx   = ioctl_addr >= GFX_BASE;
    assign rel_addr = ioctl_addr - (in_gfx ? GFX_BASE : HDR_LEN);  // Offset inside the bank
    assign byte_wr  = downloading && ioctl_wr && !header;

    // Header decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fd1089_en <= 1'b0;
            fd1094_en <= 1'b0;
            dec_type  <= 1'b0;
            game_id   <= 2'd0;
        end else if (downloading && ioctl_wr && header) begin
            if (ioctl_addr == HDR_CFG_BYTE) begin
                fd1089_en <= ioctl_dout[CFG_FD1089_BIT];
                fd1094_en <= ioctl_dout[CFG_FD1094_BIT];
                dec_type  <= ioctl_dout[CFG_TYPE_BIT];
            end
            if (ioctl_addr == HDR_ID_BYTE) begin
                game_id <= ioctl_dout[1:0];
            end
        end
    end

    // A new word wins over the ack of the previous one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_valid <= 1'b0;
        end else if (byte_wr && rel_addr[0]) begin
            prog_valid <= 1'b1;
        end else if (prog_ack) begin
            prog_valid <= 1'b0;
        end
    end

    // Even byte waits for its odd partner
    always_ff @(posedge clk) begin
        if (byte_wr) begin
            if (!rel_addr[0]) begin
                low_byte <= ioctl_dout;
            end else begin
                prog_data <= {ioctl_dout, low_byte};
                prog_addr <= rel_addr[22:1];
                prog_bank <= in_gfx ? GFX_BANK : ROM_BANK;
            end
        end
    end

    always_comb begin
        prog_req.valid = prog_valid;
        prog_req.write = 1'b1;
        prog_req.bank  = prog_bank;
        prog_req.addr  = prog_addr;
        prog_req.wdata = prog_data;
        prog_req.wmask = 2'b00;  // Full word
    end

    assign dwnld_busy = downloading | prog_valid;  // Covers the last write after the stream

endmodule

// ==== hw/sdram_if_pkg.sv ====
package sdram_if_pkg;

    // Request towards the SDRAM controller
    typedef struct packed {
        logic        valid;
        logic        write;
        logic        bank;
        logic [21:0] addr;   // Word address
        logic [15:0] wdata;
        logic [1:0]  wmask;  // Active low byte enables
    } sdram_req_t;

    // Controller answer
    typedef struct packed {
        logic        ack;    // Request taken
        logic        rdy;    // Read data valid
        logic [15:0] rdata;
    } sdram_rsp_t;

    // One client slot
    typedef struct packed {
        logic        cs;
        logic        we;
        logic [16:0] addr;   // Word address inside the region
        logic [15:0] wdata;
        logic [1:0]  dsn;    // Active low, upper byte in bit 1
    } slot_req_t;

    typedef logic [1:0] slot_id_t;

    localparam slot_id_t SLOT_RAM  = 2'd0;
    localparam slot_id_t SLOT_ROM  = 2'd1;
    localparam slot_id_t SLOT_GFX  = 2'd2;
    localparam slot_id_t SLOT_NONE = 2'd3;  // Download or nothing in flight

    localparam int SLOT_N = 3;

    // What identifies one served access of a slot
    function automatic logic [17:0] slot_key(input slot_req_t r);
        return {r.we, r.addr};
    endfunction

endpackage

// ==== hw/slot_arbiter.sv ====
`timescale 1ns/10ps

module slot_arbiter
    import mem_map_pkg::*, sdram_if_pkg::*;
#(
    parameter logic [21:0] RAM_OFS = RAM_OFFSET,
    parameter logic [21:0] ROM_OFS = ROM_OFFSET,
    parameter logic [21:0] GFX_OFS = GFX_OFFSET
) (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       downloading,
    input  sdram_req_t prog_req,
    output logic       prog_ack,

    input  slot_req_t  ram_req,
    input  slot_req_t  rom_req,
    input  slot_req_t  gfx_req,

    output sdram_req_t sdram_req,
    input  sdram_rsp_t sdram_rsp,

    output slot_id_t   rd_slot,
    output logic       rd_start,
    output slot_id_t   busy_slot
);

    localparam logic [1:0] IDLE     = 2'd0;
    localparam logic [1:0] REQ      = 2'd1;
    localparam logic [1:0] WAIT_RDY = 2'd2;

    logic [1:0]        state;
    slot_req_t         slots [SLOT_N];
    logic [SLOT_N-1:0] pend;
    logic [SLOT_N-1:0] done_v;
    logic [17:0]       done_key [SLOT_N];
    logic [17:0]       grant_key;
    logic [17:0]       iss_key;
    slot_id_t          grant;
    slot_id_t          cur_slot;
    logic              take_prog;
    logic              issue;
    logic              finish;
    sdram_req_t        nxt_req;
    sdram_req_t        req_q;
    logic              req_valid;

    assign slots[SLOT_RAM] = ram_req;
    assign slots[SLOT_ROM] = rom_req;
    assign slots[SLOT_GFX] = gfx_req;

    // A slot needs service until its current access has been served
    always_comb begin
        for (int i = 0; i < SLOT_N; i++) begin
            pend[i] = slots[i].cs && !(done_v[i] && slot_key(slots[i]) == done_key[i]);
        end
    end

    // Fixed priority: download, ram, rom, gfx
    always_comb begin
        take_prog = prog_req.valid;
        grant     = SLOT_NONE;
        grant_key = '0;
        if (!take_prog && !downloading) begin
            if (pend[SLOT_RAM]) begin
                grant     = SLOT_RAM;
                grant_key = slot_key(ram_req);
            end else if (pend[SLOT_ROM]) begin
                grant     = SLOT_ROM;
                grant_key = slot_key(rom_req);
            end else if (pend[SLOT_GFX]) begin
                grant     = SLOT_GFX;
                grant_key = slot_key(gfx_req);
            end
        end
    end

    assign issue = state == IDLE && (take_prog || grant != SLOT_NONE);

    always_comb begin
        nxt_req = prog_req;
        case (grant)
            SLOT_RAM: begin
                nxt_req.write = ram_req.we;
                nxt_req.bank  = RAM_BANK;
                nxt_req.addr  = RAM_OFS + {5'd0, ram_req.addr};
                nxt_req.wdata = ram_req.wdata;
                nxt_req.wmask = ram_req.dsn;
            end
            SLOT_ROM: begin
                nxt_req.write = 1'b0;
                nxt_req.bank  = ROM_BANK;
                nxt_req.addr  = ROM_OFS + {5'd0, rom_req.addr};
                nxt_req.wdata = 16'h0;
                nxt_req.wmask = 2'b11;
            end
            SLOT_GFX: begin
                nxt_req.write = 1'b0;
                nxt_req.bank  = GFX_BANK;
                nxt_req.addr  = GFX_OFS + {5'd0, gfx_req.addr};
                nxt_req.wdata = 16'h0;
                nxt_req.wmask = 2'b11;
            end
            default: ;
        endcase
    end

    assign rd_start = issue && grant != SLOT_NONE && !nxt_req.write;
    assign rd_slot  = grant;

    // Writes end at the ack, reads at rdy
    assign finish = (state == REQ && sdram_rsp.ack && req_q.write) ||
                    (state == WAIT_RDY && sdram_rsp.rdy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            req_valid <= 1'b0;
            cur_slot  <= SLOT_NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (issue) begin
                        state     <= REQ;
                        req_valid <= 1'b1;
                        cur_slot  <= grant;
                    end
                end
                REQ: begin
                    if (sdram_rsp.ack) begin
                        req_valid <= 1'b0;
                        state     <= req_q.write ? IDLE : WAIT_RDY;
                    end
                end
                WAIT_RDY: begin
                    if (sdram_rsp.rdy) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_q   <= nxt_req;
            iss_key <= grant_key;
        end
    end

    // Served flags drop with cs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_v <= '0;
        end else begin
            for (int i = 0; i < SLOT_N; i++) begin
                if (!slots[i].cs) begin
                    done_v[i] <= 1'b0;
                end else if (finish && cur_slot == slot_id_t'(i)) begin
                    done_v[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SLOT_N; i++) begin
            if (finish && cur_slot == slot_id_t'(i)) done_key[i] <= iss_key;
        end
    end

    always_comb begin
        sdram_req       = req_q;
        sdram_req.valid = req_valid;
    end

    assign prog_ack  = state == REQ && sdram_rsp.ack && cur_slot == SLOT_NONE;
    assign busy_slot = (state == REQ && req_q.write) ? cur_slot : SLOT_NONE;  // Slot writes only

endmodule

// ==== hw/slot_return.sv ====
`timescale 1ns/10ps

module slot_return
    import sdram_if_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        rd_start,
    input  slot_id_t    rd_slot,
    input  slot_id_t    busy_slot,
    input  sdram_rsp_t  sdram_rsp,

    input  slot_req_t   ram_req,
    input  slot_req_t   rom_req,
    input  slot_req_t   gfx_req,

    output logic [15:0] ram_data,
    output logic [15:0] rom_data,
    output logic [15:0] gfx_data,
    output logic        ram_ok,
    output logic        rom_ok,
    output logic        gfx_ok
);

    slot_req_t         slots [SLOT_N];
    slot_id_t          fly_slot;
    logic [17:0]       fly_key;
    logic [17:0]       rd_key;
    logic [17:0]       rec_key [SLOT_N];
    logic [15:0]       data_q [SLOT_N];
    logic [SLOT_N-1:0] rec_v;
    logic [SLOT_N-1:0] ok_q;
    logic [SLOT_N-1:0] rd_done;
    logic [SLOT_N-1:0] wr_done;

    assign slots[SLOT_RAM] = ram_req;
    assign slots[SLOT_ROM] = rom_req;
    assign slots[SLOT_GFX] = gfx_req;

    always_comb begin
        case (rd_slot)
            SLOT_RAM: rd_key = slot_key(ram_req);
            SLOT_ROM: rd_key = slot_key(rom_req);
            SLOT_GFX: rd_key = slot_key(gfx_req);
            default:  rd_key = '0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < SLOT_N; i++) begin
            rd_done[i] = sdram_rsp.rdy && fly_slot == slot_id_t'(i);
            wr_done[i] = sdram_rsp.ack && busy_slot == slot_id_t'(i);
        end
    end

    // Slot and address of the read in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fly_slot <= SLOT_NONE;
        end else if (rd_start) begin
            fly_slot <= rd_slot;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) fly_key <= rd_key;
        for (int i = 0; i < SLOT_N; i++) begin
            if (rd_done[i]) begin
                data_q[i]  <= sdram_rsp.rdata;
                rec_key[i] <= fly_key;
            end else if (wr_done[i]) begin
                rec_key[i] <= slot_key(slots[i]);  // Address held by the slot
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_v <= '0;
            ok_q  <= '0;
        end else begin
            for (int i = 0; i < SLOT_N; i++) begin
                if (!slots[i].cs) begin
                    rec_v[i] <= 1'b0;
                end else if (rd_done[i] || wr_done[i]) begin
                    rec_v[i] <= 1'b1;
                end
                ok_q[i] <= slots[i].cs && rec_v[i] && slot_key(slots[i]) == rec_key[i];
            end
        end
    end

    assign ram_data = data_q[SLOT_RAM];
    assign rom_data = data_q[SLOT_ROM];
    assign gfx_data = data_q[SLOT_GFX];
    assign ram_ok   = ok_q[SLOT_RAM];
    assign rom_ok   = ok_q[SLOT_ROM];
    assign gfx_ok   = ok_q[SLOT_GFX];

endmodule

// ==== outrun_mem.f ====
hw/mem_map_pkg.sv
hw/sdram_if_pkg.sv
hw/rom_dwnld.sv
hw/slot_arbiter.sv
hw/slot_return.sv
hw/outrun_mem.sv
testbench/sdram_model.sv
testbench/tb_outrun_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the outrun_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    -f outrun_mem.f \
    --top-module tb_outrun_mem \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_outrun_mem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
else
    exit 1
fi

// ==== testbench/sdram_model.sv ====
`timescale 1ns/10ps

module sdram_model
    import sdram_if_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  sdram_req_t req,
    output sdram_rsp_t rsp
);

    logic [15:0] mem [logic [22:0]];  // {bank, addr}
    integer      seed = 32'hc1964f3b;

    // Contents of a word never written
    function automatic logic [15:0] fill_word(input logic [22:0] key);
        return key[15:0] ^ {9'd0, key[22:16]} ^ 16'h3c3c;
    endfunction

    function automatic logic [15:0] read_word(input logic [22:0] key);
        if (mem.exists(key)) return mem[key];
        return fill_word(key);
    endfunction

    initial begin
        int          d;
        logic [22:0] key;
        logic [15:0] word;
        rsp <= '0;
        forever begin
            @(posedge clk);
            if (rst_n && req.valid) begin
                d = $random(seed) % 3;
                if (d < 0) d = -d;
                d = d + 1;  // Ack after 1 to 3 cycles
                repeat (d - 1) @(posedge clk);
                key  = {req.bank, req.addr};
                word = read_word(key);
                if (req.write) begin
                    if (!req.wmask[0]) word[7:0]  = req.wdata[7:0];
                    if (!req.wmask[1]) word[15:8] = req.wdata[15:8];
                    mem[key] = word;
                end
                rsp.ack <= 1'b1;
                @(posedge clk);
                rsp.ack <= 1'b0;
                if (!req.write) begin
                    @(posedge clk);
                    rsp.rdy   <= 1'b1;  // Two cycles after the ack
                    rsp.rdata <= word;
                    @(posedge clk);
                    rsp.rdy   <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_outrun_mem.sv ====
`timescale 1ns/10ps

module tb_outrun_mem
    import sdram_if_pkg::*;
;

    localparam logic [24:0] TB_GFX_BASE = 25'h30;  // 16 ROM words after the header
    localparam int          DL_BYTES    = 'h50;
    localparam int          BYTE_GAP    = 6;
    // Download, 32 reads, ram and gate tests with generous margin
    localparam int          MAX_CYCLES  = 4000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic        dwnld_busy;
    logic [1:0]  game_id;
    logic        dec_en;
    logic        dec_type;
    slot_req_t   ram_req;
    slot_req_t   rom_req;
    slot_req_t   gfx_req;
    logic [15:0] ram_data;
    logic [15:0] rom_data;
    logic [15:0] gfx_data;
    logic        ram_ok;
    logic        rom_ok;
    logic        gfx_ok;
    logic        lvbl;
    logic [8:0]  vrender;
    sdram_req_t  sdram_req;
    sdram_rsp_t  sdram_rsp;

    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    test_err_start;
    int    cycles = 0;
    string cur_test;
    logic  gate;

    always #4 clk = ~clk;

    outrun_mem #(
        .GFX_BASE    (TB_GFX_BASE)
    ) i_outrun_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .dwnld_busy  (dwnld_busy),
        .game_id     (game_id),
        .dec_en      (dec_en),
        .dec_type    (dec_type),
        .ram_req     (ram_req),
        .rom_req     (rom_req),
        .gfx_req     (gfx_req),
        .ram_data    (ram_data),
        .rom_data    (rom_data),
        .gfx_data    (gfx_data),
        .ram_ok      (ram_ok),
        .rom_ok      (rom_ok),
        .gfx_ok      (gfx_ok),
        .lvbl        (lvbl),
        .vrender     (vrender),
        .sdram_req   (sdram_req),
        .sdram_rsp   (sdram_rsp)
    );

    sdram_model u_sdram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sdram_req),
        .rsp   (sdram_rsp)
    );

    assign gate = lvbl || vrender == 9'd0 || vrender[8];  // Blanking window

    // Protocol checks
    a_ram_ok_cs: assert property (@(posedge clk) disable iff (!rst_n) ram_ok |-> $past(ram_req.cs))
        else begin $display("ram_ok high without ram cs"); errors++; end
    a_rom_ok_cs: assert property (@(posedge clk) disable iff (!rst_n) rom_ok |-> $past(rom_req.cs))
        else begin $display("rom_ok high without rom cs"); errors++; end
    a_gfx_gate: assert property (@(posedge clk) disable iff (!rst_n)
                                 gfx_ok |-> $past(gate && gfx_req.cs))
        else begin $display("gfx_ok high outside blanking"); errors++; end
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                 sdram_req.valid && !sdram_rsp.ack |=> sdram_req.valid)
        else begin $display("SDRAM request dropped before its ack"); errors++; end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Image byte at a download address
    function automatic logic [7:0] img_byte(input logic [24:0] a);
        return (a[7:0] * 8'd3) ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]} ^ 8'h5a;
    endfunction

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAILED", cur_test);
        end
    endtask

    task automatic check_val(input logic [15:0] exp, input logic [15:0] act);
        assert (exp === act) else begin
            $display("error %s: expected %h, actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic drive_slot(input slot_id_t s, input slot_req_t r);
        case (s)
            SLOT_RAM: ram_req = r;
            SLOT_ROM: rom_req = r;
            default:  gfx_req = r;
        endcase
    endtask

    function automatic logic slot_ok(input slot_id_t s);
        case (s)
            SLOT_RAM: return ram_ok;
            SLOT_ROM: return rom_ok;
            default:  return gfx_ok;
        endcase
    endfunction

    function automatic logic [15:0] slot_data(input slot_id_t s);
        case (s)
            SLOT_RAM: return ram_data;
            SLOT_ROM: return rom_data;
            default:  return gfx_data;
        endcase
    endfunction

    function automatic slot_req_t make_req(input logic we, input logic [16:0] addr,
                                           input logic [15:0] wdata, input logic [1:0] dsn);
        slot_req_t r;
        r.cs    = 1'b1;
        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        r.dsn   = dsn;
        return r;
    endfunction

    // One access, waits for ok then drops cs
    task automatic access_slot(input slot_id_t s, input slot_req_t r,
                               output logic [15:0] data);
        int n;
        bit seen;
        n    = 0;
        seen = 0;
        @(negedge clk);
        drive_slot(s, r);
        while (!seen && n < 60) begin
            @(negedge clk);
            n++;
            seen = slot_ok(s);
        end
        data = slot_data(s);
        assert (seen) else begin
            $display("%s: slot %0d gave no ok within %0d cycles", cur_test, s, n);
            errors++;
        end
        r.cs = 1'b0;
        drive_slot(s, r);
    endtask

    task automatic download_image();
        logic [7:0] b;
        int         n;
        downloading = 1'b1;
        for (int a = 0; a < DL_BYTES; a++) begin
            b = (a == 0) ? 8'h06 : (a == 1) ? 8'h02 : img_byte(25'(a));
            @(negedge clk);
            ioctl_addr = 25'(a);
            ioctl_dout = b;
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            if (a == 0) check_val(16'd0, {15'd0, dec_en});  // Flags just registered
            @(negedge clk);
            if (a == 0) check_val(16'd1, {15'd0, dec_en});
            repeat (BYTE_GAP - 3) @(negedge clk);
        end
        downloading = 1'b0;
        n = 0;
        while (dwnld_busy && n < 50) begin
            @(negedge clk);
            n++;
        end
        assert (!dwnld_busy) else begin
            $display("%s: download stayed busy after the stream", cur_test);
            errors++;
        end
    endtask

    initial begin
        logic [15:0] d;
        logic [15:0] exp;
        int          t_ram;
        int          t_rom;
        int          n;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        ram_req     = '0;
        rom_req     = '0;
        gfx_req     = '0;
        lvbl        = 1'b1;
        vrender     = 9'd0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_state");
        @(negedge clk);
        check_val(16'd0, {10'd0, ram_ok, rom_ok, gfx_ok, sdram_req.valid, dwnld_busy, dec_en});
        check_val(16'd0, {14'd0, game_id});
        end_test();

        start_test("header_and_download");
        download_image();
        check_val(16'd2, {14'd0, game_id});
        check_val(16'd1, {15'd0, dec_en});
        check_val(16'd0, {15'd0, dec_type});
        end_test();

        start_test("rom_readback");
        for (int k = 0; k < 16; k++) begin
            access_slot(SLOT_ROM, make_req(1'b0, 17'(k), 16'h0, 2'b11), d);
            check_val({img_byte(25'(16 + 2 * k + 1)), img_byte(25'(16 + 2 * k))}, d);
        end
        end_test();

        start_test("gfx_readback");
        lvbl = 1'b1;
        for (int k = 0; k < 16; k++) begin
            access_slot(SLOT_GFX, make_req(1'b0, 17'(k), 16'h0, 2'b11), d);
            exp = {img_byte(TB_GFX_BASE + 25'(2 * k + 1)), img_byte(TB_GFX_BASE + 25'(2 * k))};
            check_val(exp, d);
        end
        end_test();

        start_test("ram_byte_mask");
        access_slot(SLOT_RAM, make_req(1'b1, 17'd5, 16'h1234, 2'b00), d);
        access_slot(SLOT_RAM, make_req(1'b1, 17'd5, 16'habcd, 2'b01), d);  // Upper byte only
        access_slot(SLOT_RAM, make_req(1'b0, 17'd5, 16'h0, 2'b11), d);
        check_val(16'hab34, d);
        end_test();

        start_test("gfx_gate");
        @(negedge clk);
        lvbl    = 1'b0;
        vrender = 9'd100;
        gfx_req = make_req(1'b0, 17'd3, 16'h0, 2'b11);
        repeat (20) begin
            @(negedge clk);
            check_val(16'd0, {15'd0, gfx_ok});
        end
        lvbl = 1'b1;
        n = 0;
        while (!gfx_ok && n < 60) begin
            @(negedge clk);
            n++;
        end
        check_val(16'd1, {15'd0, gfx_ok});
        check_val({img_byte(TB_GFX_BASE + 25'd7), img_byte(TB_GFX_BASE + 25'd6)}, gfx_data);
        gfx_req.cs = 1'b0;
        end_test();

        start_test("ram_rom_priority");
        @(negedge clk);
        ram_req = make_req(1'b0, 17'd5, 16'h0, 2'b11);
        rom_req = make_req(1'b0, 17'd2, 16'h0, 2'b11);
        t_ram = -1;
        t_rom = -1;
        n = 0;
        while ((t_ram < 0 || t_rom < 0) && n < 80) begin
            @(negedge clk);
            n++;
            if (ram_ok && t_ram < 0) t_ram = n;
            if (rom_ok && t_rom < 0) t_rom = n;
        end
        assert (t_ram >= 0 && t_rom >= 0 && t_ram < t_rom) else begin
            $display("%s: ram_ok at cycle %0d did not come before rom_ok at cycle %0d",
                     cur_test, t_ram, t_rom);
            errors++;
        end
        check_val(16'hab34, ram_data);
        check_val({img_byte(25'd21), img_byte(25'd20)}, rom_data);
        ram_req.cs = 1'b0;
        rom_req.cs = 1'b0;
        end_test();

        repeat (4) @(negedge clk);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
